// File: src.f
hw/mem_pkg.sv
hw/ctrl_pkg.sv
hw/byte_counter.sv
hw/word_assembler.sv
hw/fetch_unit.sv
hw/mem_fsm.sv
hw/mem_core.sv
tb/mem_core_assertions.sv
tb/tb_mem_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mem_core testbench with Verilator.
# Exit status is non-zero when the simulation fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_mem_core \
    -o sim_mem_core

./obj_dir/sim_mem_core

// File: tb/tb_mem_core.sv
/* Testbench for mem_core. Random fetch, load, store and I/O traffic against a
   byte-array bus model, with random rdy_in pauses and io_buffer_full bursts. */
`timescale 1ns/1ps

module tb_mem_core;

    localparam int PERIOD     = 40;
    localparam int N_OPS      = 200;
    localparam int CYC_PER_OP = 30;
    localparam int MEM_BYTES  = 131072;

    logic               clk_in;
    logic               reset;
    logic               rdy_in;
    mem_pkg::byte_t     mem_din;
    mem_pkg::byte_t     mem_dout;
    mem_pkg::addr_t     mem_a;
    logic               mem_wr;
    logic               io_buffer_full;
    logic               fetch_redirect;
    mem_pkg::addr_t     fetch_pc;
    logic               inst_valid;
    mem_pkg::word_t     inst;
    mem_pkg::data_req_t dc_req;
    logic               dc_done;
    mem_pkg::word_t     dc_rdata;

    mem_pkg::byte_t     mem [0:MEM_BYTES-1];
    mem_pkg::byte_t     io_log[$];
    mem_pkg::byte_t     io_in_byte;

    integer             seed = 32'hc942_749e;
    int                 io_burst;
    logic               redirect_next;
    mem_pkg::addr_t     pc_next;
    mem_pkg::data_req_t req_next;
    mem_pkg::addr_t     expect_pc;
    logic               data_owns;
    logic               saw_done;
    int                 lat;

    mem_core #(
        .ADDR_BITS(18)
    ) dut_i (
        .clk_in        (clk_in),
        .reset         (reset),
        .rdy_in        (rdy_in),
        .mem_din       (mem_din),
        .mem_dout      (mem_dout),
        .mem_a         (mem_a),
        .mem_wr        (mem_wr),
        .io_buffer_full(io_buffer_full),
        .fetch_redirect(fetch_redirect),
        .fetch_pc      (fetch_pc),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .dc_req        (dc_req),
        .dc_done       (dc_done),
        .dc_rdata      (dc_rdata)
    );

    always #(PERIOD/2) clk_in = ~clk_in;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input mem_pkg::word_t exp,
                              input mem_pkg::word_t got);
        if (exp !== got) begin
            fail_run($sformatf("Mismatch %s exp=%08h got=%08h", name, exp, got));
        end
    endtask

    task automatic check_byte(input string name, input mem_pkg::byte_t exp,
                              input mem_pkg::byte_t got);
        if (exp !== got) begin
            fail_run($sformatf("Mismatch %s exp=%02h got=%02h", name, exp, got));
        end
    endtask

    function automatic int rand_below(input int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    // I/O region when both top valid address bits are set
    function automatic mem_pkg::byte_t model_byte(input mem_pkg::addr_t a);
        if (a[17:16] == 2'b11) begin
            model_byte = io_in_byte;
        end else begin
            model_byte = mem[a[16:0]];
        end
    endfunction

    function automatic mem_pkg::word_t model_word(input mem_pkg::addr_t a);
        model_word = {model_byte(a + 3), model_byte(a + 2), model_byte(a + 1), model_byte(a)};
    endfunction

    // bus memory answers every cycle whether or not rdy_in is high
    // and returns each read byte one cycle after its address
    always @(posedge clk_in) begin
        if (!reset) begin
            if (mem_wr) begin
                if (mem_a[17:16] == 2'b11) begin
                    if (io_buffer_full) begin
                        fail_run("I/O write issued while io_buffer_full was high");
                    end
                    io_log.push_back(mem_dout);
                end else begin
                    mem[mem_a[16:0]] = mem_dout;
                end
            end
            mem_din <= model_byte(mem_a);
        end
    end

    // drive one clock on the falling edge and check the settled outputs
    task automatic run_cycle();
        @(negedge clk_in);
        fetch_redirect = redirect_next;
        fetch_pc       = pc_next;
        dc_req         = req_next;
        rdy_in         = redirect_next ? 1'b1 : (rand_below(5) != 0);
        if (io_burst > 0) begin
            io_buffer_full = 1'b1;
            io_burst--;
        end else begin
            io_buffer_full = 1'b0;
            if (rand_below(8) == 0) begin
                io_burst = 1 + rand_below(4);
            end
        end
        if (redirect_next) begin
            expect_pc = pc_next;
        end
        #1;
        saw_done = 1'b0;
        if (!rdy_in && mem_wr) begin
            fail_run("mem_wr was high while rdy_in was low");
        end
        if (inst_valid) begin
            if (data_owns) begin
                fail_run("instruction word returned while a data access owned the bus");
            end
            check_word("inst", model_word(expect_pc), inst);
            expect_pc = expect_pc + 4;
        end
        if (rdy_in && data_owns) begin
            lat++;
        end
        if (rdy_in && dut_i.start && dc_req.en && !data_owns) begin
            data_owns = 1'b1;
            lat       = 0;
        end
        if (dc_done) begin
            if (!data_owns) begin
                fail_run("dc_done pulsed without an accepted data request");
            end
            data_owns = 1'b0;
            saw_done  = 1'b1;
        end
    endtask

    task automatic do_data(input logic store, input mem_pkg::len_t len,
                           input mem_pkg::addr_t addr, input mem_pkg::word_t wdata);
        mem_pkg::word_t exp;
        int             log_size;
        log_size       = io_log.size();
        req_next.en    = 1'b1;
        req_next.store = store;
        req_next.len   = len;
        req_next.addr  = addr;
        req_next.wdata = wdata;
        saw_done       = 1'b0;
        while (!saw_done) begin
            run_cycle();
        end
        req_next.en = 1'b0;
        if (store) begin
            if (addr[17:16] == 2'b11) begin
                if (io_log.size() != log_size + 1) begin
                    fail_run("I/O store did not add exactly one byte to the I/O log");
                end
                check_byte("io_log", wdata[7:0], io_log[$]);
            end else begin
                for (int k = 0; k <= int'(len); k++) begin
                    check_byte("mem", wdata[8*k +: 8], model_byte(addr + k));
                end
            end
        end else begin
            exp = '0;
            for (int k = 0; k <= int'(len); k++) begin
                exp[8*k +: 8] = model_byte(addr + k);
            end
            check_word("dc_rdata", exp, dc_rdata);
            if (len == 2'd3 && lat != 6) begin
                fail_run($sformatf("4-byte load finished after %0d cycles instead of 6", lat));
            end
        end
    endtask

    function automatic mem_pkg::len_t pick_len();
        case (rand_below(3))
            0: pick_len = 2'd0;
            1: pick_len = 2'd1;
            default: pick_len = 2'd3;
        endcase
    endfunction

    // watchdog sized from the op count
    initial begin
        #(longint'(N_OPS) * CYC_PER_OP * PERIOD);
        fail_run("watchdog expired before all operations completed");
    end

    initial begin
        int             op;
        mem_pkg::addr_t a;
        clk_in         = 1'b0;
        reset          = 1'b1;
        rdy_in         = 1'b1;
        io_buffer_full = 1'b0;
        fetch_redirect = 1'b0;
        fetch_pc       = '0;
        dc_req         = '0;
        mem_din        = '0;
        req_next       = '0;
        redirect_next  = 1'b0;
        pc_next        = '0;
        expect_pc      = '0;
        data_owns      = 1'b0;
        saw_done       = 1'b0;
        lat            = 0;
        io_burst       = 0;
        io_in_byte     = 8'h5a;
        // fill depends on every address bit
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = mem_pkg::byte_t'(i * 7 + (i >> 8) * 13 + (i >> 16) * 101);
        end
        repeat (3) @(negedge clk_in);
        reset = 1'b0;
        #1;
        if (mem_wr || inst_valid || dc_done) begin
            fail_run("bus outputs not idle after reset");
        end
        for (int n = 0; n < N_OPS; n++) begin
            op = rand_below(8);
            case (op)
                0: begin
                    pc_next       = mem_pkg::addr_t'($random(seed)) & 32'h0000_fffc;
                    redirect_next = 1'b1;
                    run_cycle();
                    redirect_next = 1'b0;
                end
                1, 2: begin
                    a = 32'h0001_0000 | (mem_pkg::addr_t'($random(seed)) & 32'h0000_fffb);
                    do_data(1'b0, pick_len(), a, '0);
                end
                3, 4: begin
                    a = 32'h0001_0000 | (mem_pkg::addr_t'($random(seed)) & 32'h0000_fffb);
                    do_data(1'b1, pick_len(), a, mem_pkg::word_t'($random(seed)));
                end
                5: do_data(1'b1, 2'd0, 32'h0003_0000, mem_pkg::word_t'($random(seed)));
                6: begin
                    io_in_byte = mem_pkg::byte_t'($random(seed));
                    do_data(1'b0, 2'd0, 32'h0003_0000, '0);
                end
                default: begin
                    repeat (1 + rand_below(12)) run_cycle();
                end
            endcase
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tb/mem_core_assertions.sv
/* Bus protocol checks bound into every mem_core instance. */
`timescale 1ns/1ps

module mem_core_assertions #(
    parameter int ADDR_BITS = 18
) (
    input logic           clk_in,
    input logic           reset,
    input logic           rdy_in,
    input logic           mem_wr,
    input mem_pkg::addr_t mem_a,
    input logic           io_buffer_full,
    input logic           inst_valid,
    input logic           dc_done
);

    logic io_addr;

    assign io_addr = &mem_a[ADDR_BITS-1 -: 2];

    // no write strobe during a pause
    wr_paused: assert property (@(posedge clk_in) disable iff (reset)
        !(mem_wr && !rdy_in))
        else $error("mem_wr high while rdy_in low");

    // uart buffer full blocks I/O writes
    wr_io_full: assert property (@(posedge clk_in) disable iff (reset)
        !(mem_wr && io_addr && io_buffer_full))
        else $error("I/O write while io_buffer_full high");

    // one owner per done pulse
    done_excl: assert property (@(posedge clk_in) disable iff (reset)
        !(inst_valid && dc_done))
        else $error("inst_valid and dc_done high together");

endmodule

bind mem_core mem_core_assertions #(
    .ADDR_BITS(ADDR_BITS)
) assertions_i (
    .clk_in        (clk_in),
    .reset         (reset),
    .rdy_in        (rdy_in),
    .mem_wr        (mem_wr),
    .mem_a         (mem_a),
    .io_buffer_full(io_buffer_full),
    .inst_valid    (inst_valid),
    .dc_done       (dc_done)
);

// File: hw/mem_core.sv
/* Memory side of the core: fetch and data-cache traffic over the byte bus.
   Instantiate with ADDR_BITS set to the number of decoded address bits. */
`timescale 1ns/1ps

module mem_core #(
    parameter int ADDR_BITS = 18
) (
    input  logic               clk_in,
    input  logic               reset,
    input  logic               rdy_in,
    input  mem_pkg::byte_t     mem_din,
    output mem_pkg::byte_t     mem_dout,
    output mem_pkg::addr_t     mem_a,
    output logic               mem_wr,
    input  logic               io_buffer_full,
    input  logic               fetch_redirect,
    input  mem_pkg::addr_t     fetch_pc,
    output logic               inst_valid,
    output mem_pkg::word_t     inst,
    input  mem_pkg::data_req_t dc_req,
    output logic               dc_done,
    output mem_pkg::word_t     dc_rdata
);

    logic           fetch_en;
    mem_pkg::addr_t fetch_addr;
    logic           fetch_done;
    logic           start;
    logic           step;
    logic [1:0]     index;
    logic           last;
    logic [1:0]     read_lane;
    logic           read_capture;
    logic [1:0]     write_lane;
    mem_pkg::word_t result;
    mem_pkg::len_t  xfer_len;

    // same choice as the FSM makes at IDLE, data first
    assign xfer_len = dc_req.en ? dc_req.len : mem_pkg::LEN_WORD;
    assign dc_rdata = result;

    mem_fsm #(
        .ADDR_BITS(ADDR_BITS)
    ) fsm_i (
        .clk_in        (clk_in),
        .reset         (reset),
        .rdy_in        (rdy_in),
        .fetch_en      (fetch_en),
        .fetch_addr    (fetch_addr),
        .dc_req        (dc_req),
        .io_buffer_full(io_buffer_full),
        .index         (index),
        .last          (last),
        .start         (start),
        .step          (step),
        .mem_a         (mem_a),
        .mem_wr        (mem_wr),
        .read_lane     (read_lane),
        .read_capture  (read_capture),
        .write_lane    (write_lane),
        .fetch_done    (fetch_done),
        .dc_done       (dc_done)
    );

    byte_counter counter_i (
        .clk_in(clk_in),
        .reset (reset),
        .rdy_in(rdy_in),
        .start (start),
        .len   (xfer_len),
        .step  (step),
        .index (index),
        .last  (last)
    );

    word_assembler assembler_i (
        .clk_in      (clk_in),
        .reset       (reset),
        .rdy_in      (rdy_in),
        .start       (start),
        .read_capture(read_capture),
        .read_lane   (read_lane),
        .mem_din     (mem_din),
        .wdata       (dc_req.wdata),
        .write_lane  (write_lane),
        .mem_dout    (mem_dout),
        .result      (result)
    );

    fetch_unit fetch_i (
        .clk_in        (clk_in),
        .reset         (reset),
        .rdy_in        (rdy_in),
        .fetch_redirect(fetch_redirect),
        .fetch_pc      (fetch_pc),
        .fetch_done    (fetch_done),
        .result        (result),
        .fetch_en      (fetch_en),
        .fetch_addr    (fetch_addr),
        .inst_valid    (inst_valid),
        .inst          (inst)
    );

endmodule

// File: hw/mem_fsm.sv
/* Bus controller: arbitrates data over fetch, sequences the bytes of a transfer
   and holds I/O writes while the UART buffer is full. */
`timescale 1ns/1ps

module mem_fsm #(
    parameter int ADDR_BITS = 18
) (
    input  logic               clk_in,
    input  logic               reset,
    input  logic               rdy_in,
    input  logic               fetch_en,
    input  mem_pkg::addr_t     fetch_addr,
    input  mem_pkg::data_req_t dc_req,
    input  logic               io_buffer_full,
    input  logic [1:0]         index,
    input  logic               last,
    output logic               start,
    output logic               step,
    output mem_pkg::addr_t     mem_a,
    output logic               mem_wr,
    output logic [1:0]         read_lane,
    output logic               read_capture,
    output logic [1:0]         write_lane,
    output logic               fetch_done,
    output logic               dc_done
);

    localparam mem_pkg::addr_t ADDR_MASK = (mem_pkg::addr_t'(1) << ADDR_BITS) - 1;

    ctrl_pkg::mc_state_t state;
    ctrl_pkg::owner_t    owner;
    mem_pkg::addr_t      base;
    mem_pkg::addr_t      cur_addr;
    mem_pkg::addr_t      held_a;
    logic                is_store;
    logic                drain;
    logic                issuing;
    logic                io_addr;
    logic                io_stall;

    // only the low ADDR_BITS of an address reach the bus
    assign cur_addr = (base + mem_pkg::addr_t'(index)) & ADDR_MASK;
    assign io_addr  = &cur_addr[ADDR_BITS-1 -: 2];

    // drain is the read cycle where the last byte comes back, no new address
    assign issuing  = (state == ctrl_pkg::XFER) && !drain;
    assign io_stall = is_store && io_addr && io_buffer_full;

    assign start  = (state == ctrl_pkg::IDLE) && (dc_req.en || fetch_en);
    assign step   = issuing && !io_stall;
    assign mem_wr = issuing && is_store && !io_stall && rdy_in;

    // while paused keep the last issued address so the pending read byte
    // is still on mem_din when rdy_in returns
    assign mem_a = rdy_in ? cur_addr : held_a;

    assign write_lane = index;

    assign fetch_done = (state == ctrl_pkg::FINISH) && (owner == ctrl_pkg::OWN_FETCH)
                        && rdy_in;
    assign dc_done    = (state == ctrl_pkg::FINISH) && (owner == ctrl_pkg::OWN_DATA)
                        && rdy_in;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state        <= ctrl_pkg::IDLE;
            owner        <= ctrl_pkg::OWN_FETCH;
            is_store     <= 1'b0;
            drain        <= 1'b0;
            read_capture <= 1'b0;
        end else if (rdy_in) begin
            // a read byte lands one cycle after its address
            read_capture <= issuing && !is_store;
            case (state)
                ctrl_pkg::IDLE: begin
                    if (start) begin
                        state <= ctrl_pkg::XFER;
                        // data wins over a waiting fetch
                        if (dc_req.en) begin
                            owner    <= ctrl_pkg::OWN_DATA;
                            is_store <= dc_req.store;
                        end else begin
                            owner    <= ctrl_pkg::OWN_FETCH;
                            is_store <= 1'b0;
                        end
                    end
                end
                ctrl_pkg::XFER: begin
                    if (drain) begin
                        drain <= 1'b0;
                        state <= ctrl_pkg::FINISH;
                    end else if (last && !io_stall) begin
                        if (is_store) begin
                            state <= ctrl_pkg::FINISH;
                        end else begin
                            drain <= 1'b1;
                        end
                    end
                end
                ctrl_pkg::FINISH: begin
                    state <= ctrl_pkg::IDLE;
                end
                default: begin
                    state <= ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            held_a    <= cur_addr;
            read_lane <= index;
            if (start) begin
                base <= dc_req.en ? dc_req.addr : fetch_addr;
            end
        end
    end

endmodule

// File: hw/fetch_unit.sv
/* Sequential instruction fetch. Requests the word at pc continuously, steps pc
   by 4 per returned word and drops the word in flight after a redirect. */
`timescale 1ns/1ps

module fetch_unit (
    input  logic           clk_in,
    input  logic           reset,
    input  logic           rdy_in,
    input  logic           fetch_redirect,
    input  mem_pkg::addr_t fetch_pc,
    input  logic           fetch_done,
    input  mem_pkg::word_t result,
    output logic           fetch_en,
    output mem_pkg::addr_t fetch_addr,
    output logic           inst_valid,
    output mem_pkg::word_t inst
);

    mem_pkg::addr_t pc;
    logic           stale;

    // acceptance is not visible here, so a redirect always marks the next
    // returned word as old; at worst the new pc is fetched twice
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pc       <= '0;
            stale    <= 1'b0;
            fetch_en <= 1'b0;
        end else if (rdy_in) begin
            fetch_en <= 1'b1;
            if (fetch_redirect) begin
                pc    <= fetch_pc;
                stale <= 1'b1;
            end else if (fetch_done) begin
                if (stale) begin
                    // pc already holds the redirect target
                    stale <= 1'b0;
                end else begin
                    pc <= pc + mem_pkg::addr_t'(4);
                end
            end
        end
    end

    assign fetch_addr = pc;

    // a word finishing in the redirect cycle also belongs to the old stream
    assign inst_valid = fetch_done && !stale && !fetch_redirect;
    assign inst       = result;

endmodule

// File: hw/word_assembler.sv
/* Steers bus bytes into the result word on reads and picks the outgoing
   store byte by lane on writes. */
`timescale 1ns/1ps

module word_assembler (
    input  logic           clk_in,
    input  logic           reset,
    input  logic           rdy_in,
    input  logic           start,
    input  logic           read_capture,
    input  logic [1:0]     read_lane,
    input  mem_pkg::byte_t mem_din,
    input  mem_pkg::word_t wdata,
    input  logic [1:0]     write_lane,
    output mem_pkg::byte_t mem_dout,
    output mem_pkg::word_t result
);

    logic [4:0] rd_shift;
    logic [4:0] wr_shift;

    // lane number to bit offset, little endian
    assign rd_shift = {read_lane, 3'b000};
    assign wr_shift = {write_lane, 3'b000};

    always_ff @(posedge clk_in) begin
        if (reset) begin
            result <= '0;
        end else if (rdy_in) begin
            if (start) begin
                // cleared so short loads come out zero-extended
                result <= '0;
            end else if (read_capture) begin
                result[rd_shift +: mem_pkg::BYTE_W] <= mem_din;
            end
        end
    end

    assign mem_dout = wdata[wr_shift +: mem_pkg::BYTE_W];

endmodule

// File: hw/byte_counter.sv
/* Byte index of the transfer in progress and a flag on its final byte.
   Loaded by the FSM at acceptance and stepped once per issued byte. */
`timescale 1ns/1ps

module byte_counter (
    input  logic          clk_in,
    input  logic          reset,
    input  logic          rdy_in,
    input  logic          start,
    input  mem_pkg::len_t len,
    input  logic          step,
    output logic [1:0]    index,
    output logic          last
);

    mem_pkg::len_t len_q;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            index <= 2'd0;
            len_q <= '0;
        end else if (rdy_in) begin
            if (start) begin
                index <= 2'd0;
                len_q <= len;
            end else if (step) begin
                // wraps after a full word, harmless since the FSM has moved on
                index <= index + 2'd1;
            end
        end
    end

    assign last = (index == len_q);

endmodule

// File: hw/ctrl_pkg.sv
/* Controller state and bus ownership encodings for the memory FSM. */
package ctrl_pkg;

    // IDLE arbitrates, XFER moves bytes, FINISH raises the done pulse
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        XFER   = 2'd1,
        FINISH = 2'd2
    } mc_state_t;

    // who owns the bus for the current transfer
    typedef enum logic {
        OWN_FETCH = 1'b0,
        OWN_DATA  = 1'b1
    } owner_t;

endpackage

// File: hw/mem_pkg.sv
/* Bus widths and data-port types for the byte-wide memory controller.
   Shared by the RTL and the testbench through scoped names. */
package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;
    localparam int LEN_W  = 2;

    // byte address on the external bus
    typedef logic [ADDR_W-1:0] addr_t;

    // instruction or data word
    typedef logic [WORD_W-1:0] word_t;

    typedef logic [BYTE_W-1:0] byte_t;

    // access length minus one, so 0, 1 and 3 are the legal values
    typedef logic [LEN_W-1:0] len_t;

    // length used for every instruction fetch
    localparam len_t LEN_WORD = 2'd3;

    // data-cache request, held by the requester until dc_done
    typedef struct packed {
        logic  en;
        logic  store;
        len_t  len;
        addr_t addr;
        word_t wdata;
    } data_req_t;

endpackage
